/* src.f */
+incdir+src
src/svpwm_pkg.sv
src/space_vector_modulator.sv
src/pwm_carrier.sv
src/pwm_phase_leg.sv
src/svpwm_top.sv
dv/tb_clock_gen.sv
dv/svpwm_tb.sv

/* Makefile */
# Verilator build and run for the svpwm testbench.
# Any variable below can be overridden on the make command line.

VERILATOR ?= verilator
TOP       ?= svpwm_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/svpwm_tb.sv */
`timescale 1ns/1ps
`include "svpwm_config.svh"

module svpwm_tb
    import svpwm_pkg::*;
();

    localparam int PERIOD    = `SVPWM_PERIOD;
    localparam int DUTY_MIN  = `SVPWM_DUTY_MIN;
    localparam int DUTY_MAX  = `SVPWM_DUTY_MAX;
    localparam int DEADTIME  = `SVPWM_DEADTIME;
    localparam int SQRT3_Q10 = 1774;
    localparam int TIMEOUT   = 100;

    logic       clk;
    logic       reset;
    sample_t    alpha;
    sample_t    beta;
    logic       in_valid;
    logic       in_ready;
    duty_t      duty_u;
    duty_t      duty_v;
    duty_t      duty_w;
    logic       duty_valid;
    logic [2:0] gate_hi;
    logic [2:0] gate_lo;

    logic accept;
    int   next_duty [3];
    int   exp_duty [3];
    logic exp_zero;
    int   since_accept;
    int   phase_cnt;
    int   m_count;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    svpwm_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .alpha      (alpha),
        .beta       (beta),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .duty_u     (duty_u),
        .duty_v     (duty_v),
        .duty_w     (duty_w),
        .duty_valid (duty_valid),
        .gate_hi    (gate_hi),
        .gate_lo    (gate_lo)
    );

    task automatic flag_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("Failure: %s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic int finish_duty(input int d, input logic mirror);
        int m;
        m = mirror ? PERIOD - d : d;
        return (m < DUTY_MIN) ? DUTY_MIN : ((m > DUTY_MAX) ? DUTY_MAX : m);
    endfunction

    function automatic void svm_reference(input int a, input int b,
                                          output int du, output int dv, output int dw);
        int   a3;
        int   mag_a;
        int   mag_b;
        int   t1;
        int   t2;
        int   zh;
        logic neg_b;
        a3    = (a * SQRT3_Q10) >>> 10;
        neg_b = b < 0;
        mag_a = (a3 < 0) ? -a3 : a3;
        mag_b = neg_b ? -b : b;
        if (mag_b < mag_a) begin
            t1 = mag_b;
            t2 = (mag_a - mag_b) >>> 1;
        end else begin
            t1 = (mag_b + a3) >>> 1;
            t2 = (mag_b - a3) >>> 1;
        end
        // active times onto the phases of the sector.
        if (mag_b >= mag_a) begin
            du = neg_b ? t2 : t1;
            dv = t1 + t2;
            dw = 0;
        end else if ((a3 < 0) == neg_b) begin
            du = t1 + t2;
            dv = t1;
            dw = 0;
        end else begin
            du = 0;
            dv = t1 + t2;
            dw = t2;
        end
        zh = (PERIOD - t1 - t2) >>> 1;
        du = finish_duty(du + zh, neg_b);
        dv = finish_duty(dv + zh, neg_b);
        dw = finish_duty(dw + zh, neg_b);
    endfunction

    assign accept = in_valid && in_ready;

    always_comb begin
        svm_reference(int'(alpha), int'(beta), next_duty[0], next_duty[1], next_duty[2]);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_accept <= 0;
            exp_zero     <= 1'b0;
            exp_duty[0]  <= 0;
            exp_duty[1]  <= 0;
            exp_duty[2]  <= 0;
        end else if (accept) begin
            since_accept <= 1;
            exp_zero     <= (alpha == 0) && (beta == 0);
            exp_duty[0]  <= next_duty[0];
            exp_duty[1]  <= next_duty[1];
            exp_duty[2]  <= next_duty[2];
        end else if (since_accept != 0 && since_accept < 8) begin
            since_accept <= since_accept + 1;
        end
    end

    // mirror carrier stepping once per clock over 2 * PERIOD.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase_cnt <= 0;
        end else begin
            phase_cnt <= (phase_cnt + 1) % (2 * PERIOD);
        end
    end

    assign m_count = (phase_cnt <= PERIOD) ? phase_cnt : 2 * PERIOD - phase_cnt;

    // ########################################################################
    // checks
    // ########################################################################

    a_reset_quiet: assert property (@(posedge clk) (reset && $past(reset)) |->
        (gate_hi == 3'b000 && gate_lo == 3'b000 && !duty_valid && !in_ready))
        else flag_mismatch("outputs active during reset");

    a_release_quiet: assert property (@(posedge clk) $fell(reset) |=>
        (gate_hi == 3'b000 && gate_lo == 3'b000 && !duty_valid))
        else flag_mismatch("outputs active on first edge after reset");

    a_release_ready: assert property (@(posedge clk) $fell(reset) |=> in_ready)
        else flag_mismatch("in_ready low one clock after reset release");

    a_flow_busy: assert property (@(posedge clk) disable iff (reset)
        (since_accept >= 1 && since_accept <= 6) |-> (!in_ready && !duty_valid))
        else flag_mismatch("in_ready or duty_valid high while vector in flight");

    a_flow_done: assert property (@(posedge clk) disable iff (reset)
        (since_accept == 7) |-> (in_ready && duty_valid))
        else flag_mismatch("duty_valid or in_ready missing 6 edges after accept");

    a_valid_timing: assert property (@(posedge clk) disable iff (reset)
        duty_valid |-> (since_accept == 7))
        else flag_mismatch("duty_valid pulse at the wrong edge");

    a_duty_model: assert property (@(posedge clk) disable iff (reset)
        duty_valid |-> (int'(duty_u) == exp_duty[0] && int'(duty_v) == exp_duty[1] &&
                        int'(duty_w) == exp_duty[2]))
        else flag_mismatch($sformatf("duties %0d %0d %0d, model %0d %0d %0d",
            $sampled(duty_u), $sampled(duty_v), $sampled(duty_w),
            exp_duty[0], exp_duty[1], exp_duty[2]));

    a_duty_range: assert property (@(posedge clk) disable iff (reset)
        duty_valid |-> (duty_u >= DUTY_MIN && duty_u <= DUTY_MAX &&
                        duty_v >= DUTY_MIN && duty_v <= DUTY_MAX &&
                        duty_w >= DUTY_MIN && duty_w <= DUTY_MAX))
        else flag_mismatch("duty outside clamp limits");

    a_duty_zero: assert property (@(posedge clk) disable iff (reset)
        (duty_valid && exp_zero) |->
        (duty_u == PERIOD / 2 && duty_v == PERIOD / 2 && duty_w == PERIOD / 2))
        else flag_mismatch("zero vector not centred on half the period");

    for (genvar i = 0; i < 3; i++) begin : g_leg
        int   pending;
        int   active;
        logic raw;
        logic raw_d;
        int   run;
        int   off_run;

        assign raw = m_count < active;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                pending <= 0;
                active  <= 0;
                raw_d   <= 1'b0;
                // reset counts as a fresh edge of the raw output.
                run     <= 1;
                off_run <= 0;
            end else begin
                if (duty_valid) begin
                    pending <= exp_duty[i];
                end
                if (m_count == 0) begin
                    active <= pending;
                end
                raw_d <= raw;
                if (raw != raw_d) begin
                    run <= 1;
                end else if (run <= DEADTIME) begin
                    run <= run + 1;
                end
                if (gate_hi[i] || gate_lo[i]) begin
                    off_run <= 0;
                end else if (off_run < DEADTIME) begin
                    off_run <= off_run + 1;
                end
            end
        end

        a_gate_hi: assert property (@(posedge clk) disable iff (reset)
            gate_hi[i] == (raw_d && run > DEADTIME))
            else flag_mismatch($sformatf("gate_hi[%0d] off the carrier compare", i));

        a_gate_lo: assert property (@(posedge clk) disable iff (reset)
            gate_lo[i] == (!raw_d && run > DEADTIME))
            else flag_mismatch($sformatf("gate_lo[%0d] off the carrier compare", i));

        a_exclusive: assert property (@(posedge clk) disable iff (reset)
            !(gate_hi[i] && gate_lo[i]))
            else flag_mismatch($sformatf("both gates of leg %0d high", i));

        a_dead_gap: assert property (@(posedge clk) disable iff (reset)
            ($rose(gate_hi[i]) || $rose(gate_lo[i])) |-> (off_run >= DEADTIME))
            else flag_mismatch($sformatf("dead time too short on leg %0d", i));
    end

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic await_reset_release();
        int waited;
        waited = 0;
        @(posedge clk);
        while (reset) begin
            waited++;
            if (waited > TIMEOUT) abort_run("reset was never released");
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic send_vector(input int a, input int b);
        int waited;
        waited = 0;
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT) abort_run("in_ready stayed low for 100 cycles");
            @(negedge clk);
        end
        alpha    = sample_t'(a);
        beta     = sample_t'(b);
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 0;
        while (!duty_valid) begin
            waited++;
            if (waited > TIMEOUT) abort_run("duty_valid did not pulse within 100 cycles");
            @(negedge clk);
        end
    endtask

    initial begin
        int seed_val;
        int lim;
        int n;
        alpha    = '0;
        beta     = '0;
        in_valid = 1'b0;
        seed_val = $urandom(32'h5d01_fcc4);
        await_reset_release();
        send_vector(0, 0);
        repeat (2 * PERIOD + 50) @(negedge clk);
        // every third vector large enough to hit the clamp.
        for (n = 0; n < 24; n++) begin
            lim = (n % 3 == 0) ? 4000 : 1500;
            send_vector(int'($urandom_range(2 * lim)) - lim,
                        int'($urandom_range(2 * lim)) - lim);
            repeat ($urandom_range(7000, 20)) @(negedge clk);
        end
        repeat (4 * PERIOD) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 8 cycles, dropped on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* src/svpwm_top.sv */
`timescale 1ns/1ps
`include "svpwm_config.svh"

module svpwm_top
    import svpwm_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  sample_t    alpha,
    input  sample_t    beta,
    input  logic       in_valid,
    output logic       in_ready,
    output duty_t      duty_u,
    output duty_t      duty_v,
    output duty_t      duty_w,
    output logic       duty_valid,
    output logic [2:0] gate_hi,
    output logic [2:0] gate_lo
);

    duty_t carrier_count;
    logic  period_start;

    space_vector_modulator u_modulator (
        .clk        (clk),
        .reset      (reset),
        .alpha      (alpha),
        .beta       (beta),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .duty_u     (duty_u),
        .duty_v     (duty_v),
        .duty_w     (duty_w),
        .duty_valid (duty_valid)
    );

    pwm_carrier u_carrier (
        .clk           (clk),
        .reset         (reset),
        .carrier_count (carrier_count),
        .period_start  (period_start)
    );

    // ########################################################################
    // inverter legs, bit 0 is phase u
    // ########################################################################

    pwm_phase_leg u_leg_u (
        .clk           (clk),
        .reset         (reset),
        .duty          (duty_u),
        .duty_load     (duty_valid),
        .carrier_count (carrier_count),
        .period_start  (period_start),
        .gate_hi       (gate_hi[0]),
        .gate_lo       (gate_lo[0])
    );

    pwm_phase_leg u_leg_v (
        .clk           (clk),
        .reset         (reset),
        .duty          (duty_v),
        .duty_load     (duty_valid),
        .carrier_count (carrier_count),
        .period_start  (period_start),
        .gate_hi       (gate_hi[1]),
        .gate_lo       (gate_lo[1])
    );

    pwm_phase_leg u_leg_w (
        .clk           (clk),
        .reset         (reset),
        .duty          (duty_w),
        .duty_load     (duty_valid),
        .carrier_count (carrier_count),
        .period_start  (period_start),
        .gate_hi       (gate_hi[2]),
        .gate_lo       (gate_lo[2])
    );

endmodule

/* src/pwm_phase_leg.sv */
`timescale 1ns/1ps
`include "svpwm_config.svh"

module pwm_phase_leg
    import svpwm_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  duty_t duty,
    input  logic  duty_load,
    input  duty_t carrier_count,
    input  logic  period_start,
    output logic  gate_hi,
    output logic  gate_lo
);

    localparam int DT_W = $clog2(`SVPWM_DEADTIME + 1);

    duty_t           pending_duty;
    duty_t           active_duty;
    logic            raw;
    logic            raw_q;
    logic [DT_W-1:0] dead_cnt;

    // shadow register, applied at the carrier zero point.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending_duty <= '0;
            active_duty  <= '0;
        end else begin
            if (duty_load) begin
                pending_duty <= duty;
            end
            if (period_start) begin
                active_duty <= pending_duty;
            end
        end
    end

    assign raw = carrier_count < active_duty;

    // ########################################################################
    // dead time, both gates off on every edge of raw
    // ########################################################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raw_q    <= 1'b0;
            dead_cnt <= DT_W'(`SVPWM_DEADTIME);
            gate_hi  <= 1'b0;
            gate_lo  <= 1'b0;
        end else begin
            raw_q <= raw;
            if (raw != raw_q) begin
                gate_hi  <= 1'b0;
                gate_lo  <= 1'b0;
                dead_cnt <= DT_W'(`SVPWM_DEADTIME);
            end else if (dead_cnt == DT_W'(1)) begin
                dead_cnt <= '0;
                gate_hi  <= raw_q;
                gate_lo  <= !raw_q;
            end else if (dead_cnt != '0) begin
                dead_cnt <= dead_cnt - 1'b1;
            end
        end
    end

    a_no_shoot_through: assert property (@(posedge clk) disable iff (reset)
        !(gate_hi && gate_lo))
        else $error("high and low side on together");

endmodule

/* src/pwm_carrier.sv */
`timescale 1ns/1ps
`include "svpwm_config.svh"

module pwm_carrier
    import svpwm_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output duty_t carrier_count,
    output logic  period_start
);

    localparam duty_t PEAK = duty_t'(`SVPWM_PERIOD);

    logic count_up;

    // ########################################################################
    // triangle counter, 0 up to PEAK and back
    // ########################################################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            carrier_count <= '0;
            count_up      <= 1'b1;
        end else if (count_up) begin
            carrier_count <= carrier_count + 1'b1;
            // turn at the peak.
            if (carrier_count == PEAK - 1'b1) begin
                count_up <= 1'b0;
            end
        end else begin
            carrier_count <= carrier_count - 1'b1;
            if (carrier_count == duty_t'(1)) begin
                count_up <= 1'b1;
            end
        end
    end

    // zero point, one clock per pwm period.
    assign period_start = (carrier_count == '0);

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        carrier_count <= PEAK)
        else $error("carrier count above peak");

endmodule

/* src/space_vector_modulator.sv */
`timescale 1ns/1ps
`include "svpwm_config.svh"

module space_vector_modulator
    import svpwm_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  sample_t alpha,
    input  sample_t beta,
    input  logic    in_valid,
    output logic    in_ready,
    output duty_t   duty_u,
    output duty_t   duty_v,
    output duty_t   duty_w,
    output logic    duty_valid
);

    localparam int W    = `SVPWM_DATA_WIDTH;
    localparam int FRAC = 10;

    // sqrt(3) in q10.
    localparam logic signed [11:0] SQRT3 = 12'sd1774;

    localparam sample_t PERIOD_S   = sample_t'(`SVPWM_PERIOD);
    localparam sample_t DUTY_MIN_S = sample_t'(`SVPWM_DUTY_MIN);
    localparam sample_t DUTY_MAX_S = sample_t'(`SVPWM_DUTY_MAX);
    localparam duty_t   DUTY_LO    = duty_t'(`SVPWM_DUTY_MIN);
    localparam duty_t   DUTY_HI    = duty_t'(`SVPWM_DUTY_MAX);

    logic       accept;
    logic       ready_init;
    logic       captured;
    logic [4:0] busy;

    sample_t a_r, b_r;
    logic signed [W+11:0] a_prod;
    sample_t s1_a_sqrt3, s1_abs_b;
    logic    s1_inv;
    sample_t abs_a;
    sample_t s2_t1, s2_t2;
    logic    s2_small, s2_same, s2_inv;
    sample_t zero_half;
    sample_t base_u, base_v, base_w;
    sample_t s3_u, s3_v, s3_w;
    logic    s3_inv;
    sample_t s4_u, s4_v, s4_w;
    sample_t s5_u, s5_v, s5_w;

    function automatic sample_t clamp_duty(input sample_t x);
        if (x < DUTY_MIN_S) begin
            return DUTY_MIN_S;
        end
        if (x > DUTY_MAX_S) begin
            return DUTY_MAX_S;
        end
        return x;
    endfunction

    assign accept = in_valid && in_ready;
    assign a_prod = a_r * SQRT3;
    assign abs_a  = s1_a_sqrt3[W-1] ? -s1_a_sqrt3 : s1_a_sqrt3;

    // half of the zero-vector time.
    assign zero_half = (PERIOD_S - s2_t1 - s2_t2) >>> 1;

    // ########################################################################
    // sector decode
    // ########################################################################

    always_comb begin
        if (s2_small) begin
            if (s2_same) begin
                base_u = s2_t1 + s2_t2;
                base_v = s2_t1;
                base_w = '0;
            end else begin
                base_u = '0;
                base_v = s2_t1 + s2_t2;
                base_w = s2_t2;
            end
        end else begin
            base_u = s2_inv ? s2_t2 : s2_t1;
            base_v = s2_t1 + s2_t2;
            base_w = '0;
        end
    end

    // datapath, one stage per clock.
    always_ff @(posedge clk) begin
        if (accept) begin
            a_r <= alpha;
            b_r <= beta;
        end
        s1_a_sqrt3 <= a_prod[FRAC +: W];
        s1_abs_b   <= b_r[W-1] ? -b_r : b_r;
        s1_inv     <= b_r[W-1];
        s2_small   <= s1_abs_b < abs_a;
        s2_same    <= s1_a_sqrt3[W-1] == s1_inv;
        s2_inv     <= s1_inv;
        if (s1_abs_b < abs_a) begin
            s2_t1 <= s1_abs_b;
            s2_t2 <= (abs_a - s1_abs_b) >>> 1;
        end else begin
            s2_t1 <= (s1_abs_b + s1_a_sqrt3) >>> 1;
            s2_t2 <= (s1_abs_b - s1_a_sqrt3) >>> 1;
        end
        s3_u   <= base_u + zero_half;
        s3_v   <= base_v + zero_half;
        s3_w   <= base_w + zero_half;
        s3_inv <= s2_inv;
        // lower half plane mirrors about the period.
        s4_u <= s3_inv ? PERIOD_S - s3_u : s3_u;
        s4_v <= s3_inv ? PERIOD_S - s3_v : s3_v;
        s4_w <= s3_inv ? PERIOD_S - s3_w : s3_w;
        s5_u <= clamp_duty(s4_u);
        s5_v <= clamp_duty(s4_v);
        s5_w <= clamp_duty(s4_w);
        if (busy[4]) begin
            duty_u <= duty_t'(s5_u);
            duty_v <= duty_t'(s5_v);
            duty_w <= duty_t'(s5_w);
        end
    end

    // ########################################################################
    // flow control
    // ########################################################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_ready   <= 1'b0;
            ready_init <= 1'b1;
            captured   <= 1'b0;
            busy       <= '0;
            duty_valid <= 1'b0;
        end else begin
            ready_init <= 1'b0;
            captured   <= accept;
            busy       <= {busy[3:0], captured};
            duty_valid <= busy[4];
            if (ready_init || busy[4]) begin
                in_ready <= 1'b1;
            end
            if (accept) begin
                in_ready <= 1'b0;
            end
        end
    end

    a_duty_in_range: assert property (@(posedge clk) disable iff (reset)
        duty_valid |-> (duty_u >= DUTY_LO && duty_u <= DUTY_HI &&
                        duty_v >= DUTY_LO && duty_v <= DUTY_HI &&
                        duty_w >= DUTY_LO && duty_w <= DUTY_HI))
        else $error("duty outside clamp limits");

    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        accept |=> !in_ready [*5])
        else $error("in_ready raised while a vector is in flight");

endmodule

/* src/svpwm_pkg.sv */
`include "svpwm_config.svh"

package svpwm_pkg;

    // ########################################################################
    // shared value types
    // ########################################################################

    // stationary-frame voltage sample, two's complement.
    typedef logic signed [`SVPWM_DATA_WIDTH-1:0] sample_t;

    // phase duty in carrier counts.
    typedef logic [`SVPWM_DATA_WIDTH-1:0] duty_t;

endpackage

/* src/svpwm_config.svh */
`ifndef SVPWM_CONFIG_SVH
`define SVPWM_CONFIG_SVH

// width of every sample and duty value.
`define SVPWM_DATA_WIDTH 16

// carrier peak count, half the pwm period in clocks.
`define SVPWM_PERIOD 3000

// duty clamp limits in carrier counts.
`define SVPWM_DUTY_MIN 20
`define SVPWM_DUTY_MAX 2980

// dead time in clocks.
`define SVPWM_DEADTIME 10

`endif
